// ==== logic/calc_pkg.sv ====
`default_nettype none

package calc_pkg;

    // opcode field sits in the low bits of an operator keycode
    localparam int OPCODE_W = 3;

    typedef enum logic [OPCODE_W-1:0] {
        op_add    = 3'd0,
        op_sub    = 3'd1,  // carry reports the borrow
        op_and    = 3'd2,
        op_or     = 3'd3,
        op_xor    = 3'd4,
        op_shl    = 3'd5,  // shift amount from operand_b[2:0]
        op_shr    = 3'd6,
        op_pass_b = 3'd7
    } calc_op_e;

    // keypad entry states
    typedef enum logic [2:0] {
        st_locked     = 3'd0,  // disarmed until w_en rises
        st_collect    = 3'd1,  // shifting in key presses
        st_stored     = 3'd2,  // full word, store_dig high
        st_wait_cmd   = 3'd3,  // waiting for enter or result
        st_num_enter  = 3'd4,  // enter pulse
        st_result_req = 3'd5,  // result request pulse
        st_wait_more  = 3'd6   // next press or r_en
    } key_state_e;

endpackage

`default_nettype wire

// ==== logic/entry_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// operands and opcode from the decoder, execute request to the alu
interface entry_if
    import calc_pkg::*;
#(
    parameter int OPERAND_W = 8
) ();

    logic [OPERAND_W-1:0] operand_a;  // older stack entry
    logic [OPERAND_W-1:0] operand_b;  // newest stack entry
    calc_op_e             opcode;
    logic                 exec;       // one-cycle pulse

    modport decode (
        output operand_a, operand_b, opcode, exec
    );

    modport execute (
        input operand_a, operand_b, opcode, exec
    );

endinterface

`default_nettype wire

// ==== logic/key_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_encoder
    import calc_pkg::*;
#(
    parameter int OPERAND_W = 8
) (
    input  logic               clk,
    input  logic               nrst,
    input  logic [1:0]         keypad,
    input  logic               is_op,
    input  logic               is_result,
    input  logic               is_enter,
    input  logic               w_en,
    input  logic               r_en,
    output logic [OPERAND_W:0] keycode,
    output logic               store_dig,
    output logic               enter,
    output logic               result_req
);

    localparam int CODE_W = OPERAND_W + 1;
    localparam int CNT_W  = $clog2(CODE_W + 1);

    logic [1:0]       keypad_meta;
    logic [1:0]       keypad_sync;
    logic [1:0]       keypad_prev;  // delayed copy for press edges
    logic             w_en_q;
    logic             w_en_rise;
    logic             strobe;
    logic             count_press;
    logic             shift_en;
    logic             shift_bit;
    logic [CNT_W-1:0] bit_cnt;
    key_state_e       state;
    key_state_e       next_state;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            keypad_meta <= '0;
            keypad_sync <= '0;
            keypad_prev <= '0;
            w_en_q      <= 1'b0;
            state       <= st_locked;
            keycode     <= '0;
        end else begin
            keypad_meta <= keypad;
            keypad_sync <= keypad_meta;
            keypad_prev <= keypad_sync;
            w_en_q      <= w_en;
            state       <= next_state;
            if (shift_en) begin
                keycode <= {keycode[OPERAND_W-1:0], shift_bit};
            end
        end
    end

    // press = keypad leaves all-zero
    assign strobe    = (|keypad_sync) && !(|keypad_prev);
    assign w_en_rise = w_en && !w_en_q;

    // 01 gives 0, 10 gives 1, 11 counts but shifts nothing
    assign shift_bit = keypad_sync[1];
    assign shift_en  = count_press && (keypad_sync != 2'b11);

    always_comb begin
        next_state  = state;
        count_press = 1'b0;
        case (state)
            st_locked: begin
                if (w_en_rise)
                    next_state = st_collect;
            end
            st_collect: begin
                if (strobe) begin
                    count_press = 1'b1;
                    if (bit_cnt == CNT_W'(OPERAND_W))  // last bit of the word
                        next_state = st_stored;
                end
            end
            st_stored:   next_state = st_wait_cmd;
            st_wait_cmd: begin
                if (is_enter)
                    next_state = st_num_enter;
                else if (is_op && is_result)
                    next_state = st_result_req;
            end
            st_num_enter,
            st_result_req: next_state = st_wait_more;  // commands ignored from here
            st_wait_more: begin
                if (r_en) begin
                    next_state = st_locked;
                end else if (strobe) begin
                    // this press is the first bit of the next word
                    count_press = 1'b1;
                    next_state  = st_collect;
                end
            end
            default: next_state = st_locked;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            bit_cnt <= '0;
        end else if (count_press) begin
            if (state == st_wait_more)
                bit_cnt <= CNT_W'(1);
            else if (next_state == st_stored)
                bit_cnt <= '0;
            else
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    assign store_dig  = (state == st_stored);
    assign enter      = (state == st_num_enter);
    assign result_req = (state == st_result_req);

    // the word counter wraps at the last bit of a word
    a_cnt_in_range: assert property (@(posedge clk) disable iff (!nrst)
        bit_cnt <= CNT_W'(OPERAND_W))
        else $error("key_encoder: bit counter past the word length");

endmodule

`default_nettype wire

// ==== logic/entry_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module entry_decoder
    import calc_pkg::*;
#(
    parameter int OPERAND_W = 8
) (
    input  logic               clk,
    input  logic               nrst,
    input  logic [OPERAND_W:0] keycode,
    input  logic               enter,
    input  logic               result_req,
    entry_if.decode            entry,
    output logic               clear
);

    logic is_operator;

    assign is_operator = keycode[OPERAND_W];  // top bit marks an operator

    // two-deep operand stack, newest value in operand_b
    always_ff @(posedge clk) begin
        if (enter && !is_operator) begin
            entry.operand_a <= entry.operand_b;
            entry.operand_b <= keycode[OPERAND_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            entry.opcode <= op_add;
            entry.exec   <= 1'b0;
        end else begin
            entry.exec <= result_req;  // stack is settled by now
            if (enter && is_operator) begin
                entry.opcode <= calc_op_e'(keycode[OPCODE_W-1:0]);
            end
        end
    end

    // any new entry invalidates the shown result
    assign clear = enter;

    // an execute must never see a stack that is still being written
    a_no_exec_after_enter: assert property (@(posedge clk) disable iff (!nrst)
        enter |=> !$rose(entry.exec))
        else $error("entry_decoder: exec right after enter");

endmodule

`default_nettype wire

// ==== logic/calc_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module calc_alu
    import calc_pkg::*;
#(
    parameter int OPERAND_W = 8
) (
    input  logic                 clk,
    input  logic                 nrst,
    entry_if.execute             entry,
    output logic [OPERAND_W-1:0] alu_value,
    output logic                 alu_carry,
    output logic                 alu_done
);

    logic [OPERAND_W-1:0] op_a;
    logic [OPERAND_W-1:0] op_b;
    logic [2:0]           shamt;
    logic [OPERAND_W-1:0] calc_value;
    logic                 calc_carry;

    assign op_a  = entry.operand_a;
    assign op_b  = entry.operand_b;
    assign shamt = op_b[2:0];

    always_comb begin
        calc_value = '0;
        calc_carry = 1'b0;
        case (entry.opcode)
            op_add: {calc_carry, calc_value} = {1'b0, op_a} + {1'b0, op_b};
            op_sub: {calc_carry, calc_value} = {1'b0, op_a} - {1'b0, op_b};  // top bit = borrow
            op_and: calc_value = op_a & op_b;
            op_or:  calc_value = op_a | op_b;
            op_xor: calc_value = op_a ^ op_b;
            // last bit out lands in the carry slot and is 0 for a zero shift
            op_shl: {calc_carry, calc_value} = {1'b0, op_a} << shamt;
            op_shr: {calc_value, calc_carry} = {op_a, 1'b0} >> shamt;
            op_pass_b: calc_value = op_b;
            default: begin
                calc_value = '0;
                calc_carry = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (entry.exec) begin
            alu_value <= calc_value;
            alu_carry <= calc_carry;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst)
            alu_done <= 1'b0;
        else
            alu_done <= entry.exec;
    end

    // one request gives exactly one alu_done pulse
    a_exec_one_cycle: assert property (@(posedge clk) disable iff (!nrst)
        entry.exec |=> !entry.exec)
        else $error("calc_alu: exec held longer than one cycle");

endmodule

`default_nettype wire

// ==== logic/result_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_unit #(
    parameter int OPERAND_W = 8
) (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic [OPERAND_W-1:0] alu_value,
    input  logic                 alu_carry,
    input  logic                 alu_done,
    input  logic                 clear,
    output logic [OPERAND_W-1:0] result,
    output logic                 carry,
    output logic                 zero,
    output logic                 result_valid
);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            result       <= '0;
            carry        <= 1'b0;
            zero         <= 1'b0;
            result_valid <= 1'b0;
        end else if (alu_done) begin
            result       <= alu_value;
            carry        <= alu_carry;
            zero         <= (alu_value == '0);
            result_valid <= 1'b1;
        end else if (clear) begin
            result_valid <= 1'b0;  // old value stays on result
        end
    end

endmodule

`default_nettype wire

// ==== logic/keypad_calc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module keypad_calc_top #(
    parameter int OPERAND_W = 8
) (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic [1:0]           keypad,
    input  logic                 is_op,
    input  logic                 is_result,
    input  logic                 is_enter,
    input  logic                 w_en,
    input  logic                 r_en,
    output logic [OPERAND_W:0]   keycode,
    output logic                 store_dig,
    output logic [OPERAND_W-1:0] result,
    output logic                 carry,
    output logic                 zero,
    output logic                 result_valid
);

    logic                 enter;
    logic                 result_req;
    logic                 clear;
    logic [OPERAND_W-1:0] alu_value;
    logic                 alu_carry;
    logic                 alu_done;

    entry_if #(.OPERAND_W(OPERAND_W)) entry_bus ();

    key_encoder #(.OPERAND_W(OPERAND_W)) key_enc0 (
        .clk        (clk),
        .nrst       (nrst),
        .keypad     (keypad),
        .is_op      (is_op),
        .is_result  (is_result),
        .is_enter   (is_enter),
        .w_en       (w_en),
        .r_en       (r_en),
        .keycode    (keycode),
        .store_dig  (store_dig),
        .enter      (enter),
        .result_req (result_req)
    );

    entry_decoder #(.OPERAND_W(OPERAND_W)) entry_dec0 (
        .clk        (clk),
        .nrst       (nrst),
        .keycode    (keycode),
        .enter      (enter),
        .result_req (result_req),
        .entry      (entry_bus.decode),
        .clear      (clear)
    );

    calc_alu #(.OPERAND_W(OPERAND_W)) alu0 (
        .clk       (clk),
        .nrst      (nrst),
        .entry     (entry_bus.execute),
        .alu_value (alu_value),
        .alu_carry (alu_carry),
        .alu_done  (alu_done)
    );

    result_unit #(.OPERAND_W(OPERAND_W)) res0 (
        .clk          (clk),
        .nrst         (nrst),
        .alu_value    (alu_value),
        .alu_carry    (alu_carry),
        .alu_done     (alu_done),
        .clear        (clear),
        .result       (result),
        .carry        (carry),
        .zero         (zero),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

// ==== dv/keypad_calc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module keypad_calc_tb
    import calc_pkg::*;
();

    localparam int OPERAND_W  = 8;
    localparam int CODE_W     = OPERAND_W + 1;
    localparam int WAIT_LIMIT = 40;  // cycles

    logic                 clk;
    logic                 nrst;
    logic [1:0]           keypad;
    logic                 is_op;
    logic                 is_result;
    logic                 is_enter;
    logic                 w_en;
    logic                 r_en;
    logic [OPERAND_W:0]   keycode;
    logic                 store_dig;
    logic                 carry;
    logic                 zero;
    logic                 result_valid;
    logic [OPERAND_W-1:0] result;

    // reference model of the operand stack, pending opcode and keycode register
    logic [OPERAND_W-1:0] model_a;
    logic [OPERAND_W-1:0] model_b;
    calc_op_e             model_op;
    logic [OPERAND_W:0]   model_code;
    integer               seed;
    logic [31:0]          rnd;

    keypad_calc_top #(.OPERAND_W(OPERAND_W)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #1;  // drive and sample just after the edge
    endtask

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [OPERAND_W-1:0] got,
                               input logic [OPERAND_W-1:0] exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0t: %s is %h, expected %h",
                               $time, what, got, exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("Mismatch at %0t: %s is %b, expected %b",
                               $time, what, got, exp));
    endtask

    task automatic check_keycode(input logic [OPERAND_W:0] exp);
        if (keycode !== exp)
            stop_run($sformatf("Mismatch at %0t: keycode is %h, expected %h",
                               $time, keycode, exp));
    endtask

    task automatic check_result(input logic [OPERAND_W-1:0] exp_value, input logic exp_carry);
        check_value("result", result, exp_value);
        check_flag("carry", carry, exp_carry);
        check_flag("zero", zero, exp_value == '0);
    endtask

    // expected {carry, value} for one operation
    function automatic logic [OPERAND_W:0] model_calc(input logic [OPERAND_W-1:0] a,
                                                      input logic [OPERAND_W-1:0] b,
                                                      input calc_op_e op);
        int                   sh;
        int                   sum;
        logic [OPERAND_W-1:0] v;
        logic                 c;
        sh = int'(b[2:0]);
        v  = '0;
        c  = 1'b0;
        case (op)
            op_add: begin
                sum = int'(a) + int'(b);
                v   = sum[OPERAND_W-1:0];
                c   = (sum >= (1 << OPERAND_W));
            end
            op_sub: begin
                v = a - b;
                c = (a < b);  // borrow
            end
            op_and: v = a & b;
            op_or:  v = a | b;
            op_xor: v = a ^ b;
            op_shl: begin
                v = a << sh;
                c = (sh == 0) ? 1'b0 : a[OPERAND_W - sh];
            end
            op_shr: begin
                v = a >> sh;
                c = (sh == 0) ? 1'b0 : a[sh - 1];
            end
            default: v = b;  // op_pass_b
        endcase
        return {c, v};
    endfunction

    // 01 shifts a 0, 10 shifts a 1, 11 counts only
    function automatic logic [OPERAND_W:0] shift_code(input logic [OPERAND_W:0] code,
                                                      input logic [1:0] key);
        if (key == 2'b11)
            return code;
        return {code[OPERAND_W-1:0], key[1]};
    endfunction

    task automatic press_bit(input logic [1:0] key);
        model_code = shift_code(model_code, key);
        keypad = key;
        repeat (6) tick();
        keypad = 2'b00;
        repeat (6) tick();
    endtask

    // arm, press msb first, key at blank_pos is 11
    task automatic enter_word(input logic [OPERAND_W:0] word, input int blank_pos);
        int         i;
        int         n;
        logic [1:0] key;
        w_en = 1'b1;
        tick();
        w_en = 1'b0;
        tick();
        for (i = CODE_W - 1; i >= 0; i--) begin
            key = (i == blank_pos) ? 2'b11 : (word[i] ? 2'b10 : 2'b01);
            if (i > 0) begin
                press_bit(key);
            end else begin
                // last key is held until the word is stored
                model_code = shift_code(model_code, key);
                keypad = key;
                n = 0;
                while (!store_dig) begin
                    if (n == WAIT_LIMIT)
                        stop_run("Timeout: store_dig never came after the last key press");
                    tick();
                    n++;
                end
                check_keycode(model_code);
                tick();
                check_flag("store_dig one cycle later", store_dig, 1'b0);
                keypad = 2'b00;
                repeat (6) tick();
            end
        end
    endtask

    task automatic do_enter();
        is_enter = 1'b1;
        repeat (3) tick();
        is_enter = 1'b0;
        tick();  // stack settles
    endtask

    task automatic do_result();
        is_op     = 1'b1;
        is_result = 1'b1;
        repeat (3) tick();
        is_op     = 1'b0;
        is_result = 1'b0;
    endtask

    // number entries push, operator entries set the opcode
    task automatic store_entry();
        do_enter();
        if (model_code[OPERAND_W]) begin
            model_op = calc_op_e'(model_code[OPCODE_W-1:0]);
        end else begin
            model_a = model_b;
            model_b = model_code[OPERAND_W-1:0];
        end
    endtask

    task automatic push_number(input logic [OPERAND_W-1:0] value);
        enter_word({1'b0, value}, -1);
        store_entry();
    endtask

    task automatic set_operator(input calc_op_e op);
        enter_word({1'b1, {(OPERAND_W - OPCODE_W){1'b0}}, op}, -1);
        store_entry();
    endtask

    task automatic request_result();
        logic [OPERAND_W:0] exp;
        int                 n;
        exp = model_calc(model_a, model_b, model_op);
        enter_word({1'b1, {(OPERAND_W - OPCODE_W){1'b0}}, model_op}, -1);
        check_flag("result_valid before request", result_valid, 1'b0);
        do_result();
        n = 0;
        while (!result_valid) begin
            if (n == WAIT_LIMIT)
                stop_run("Timeout: result_valid never rose after the result request");
            tick();
            n++;
        end
        check_result(exp[OPERAND_W-1:0], exp[OPERAND_W]);
    endtask

    task automatic run_op(input logic [OPERAND_W-1:0] a, input logic [OPERAND_W-1:0] b,
                          input calc_op_e op);
        push_number(a);
        push_number(b);
        set_operator(op);
        request_result();
    endtask

    task automatic release_keypad();
        r_en = 1'b1;
        repeat (2) tick();
        r_en = 1'b0;
        tick();
    endtask

    // a full word of presses on a locked keypad leaves keycode alone
    task automatic press_locked();
        int i;
        for (i = 0; i < CODE_W; i++) begin
            keypad = 2'b10;
            repeat (6) tick();
            keypad = 2'b00;
            repeat (6) tick();
        end
        check_keycode(model_code);
    endtask

    // a locked keypad must give no result_valid at all
    task automatic expect_no_result();
        int n;
        do_result();
        for (n = 0; n < WAIT_LIMIT; n++) begin
            if (result_valid)
                stop_run("result_valid rose although the keypad was locked");
            tick();
        end
    endtask

    initial begin
        int                 k;
        logic [OPERAND_W:0] last;
        seed       = 32'hfcae;
        nrst       = 1'b0;
        keypad     = 2'b00;
        is_op      = 1'b0;
        is_result  = 1'b0;
        is_enter   = 1'b0;
        w_en       = 1'b0;
        r_en       = 1'b0;
        model_a    = '0;
        model_b    = '0;
        model_op   = op_add;
        model_code = '0;
        repeat (3) @(posedge clk);
        #1;
        nrst = 1'b1;
        tick();

        check_flag("result_valid", result_valid, 1'b0);
        check_flag("store_dig", store_dig, 1'b0);
        check_flag("carry", carry, 1'b0);
        check_flag("zero", zero, 1'b0);
        check_value("result", result, '0);
        check_keycode('0);
        expect_no_result();  // no w_en yet so still st_locked

        // plain word, then a word with one 11 press
        push_number(8'ha5);
        enter_word(9'h03c, 3);
        store_entry();

        for (k = 0; k < 16; k++) begin
            rnd = $random(seed);
            run_op(rnd[OPERAND_W-1:0], rnd[15:8], calc_op_e'(k[2:0]));
        end
        run_op(8'hff, 8'h01, op_add);
        run_op(8'h00, 8'h01, op_sub);

        // three pushes keep the last two
        push_number(8'h11);
        push_number(8'h5a);
        push_number(8'h23);
        set_operator(op_sub);
        request_result();
        set_operator(op_pass_b);
        request_result();

        last = model_calc(model_a, model_b, model_op);  // value now on result
        push_number(8'h42);
        check_flag("result_valid after enter", result_valid, 1'b0);
        check_result(last[OPERAND_W-1:0], last[OPERAND_W]);
        release_keypad();  // back to st_locked
        press_locked();
        expect_no_result();
        check_result(last[OPERAND_W-1:0], last[OPERAND_W]);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== keypad_calc_top.f ====
logic/calc_pkg.sv
logic/entry_if.sv
logic/key_encoder.sv
logic/entry_decoder.sv
logic/calc_alu.sv
logic/result_unit.sv
logic/keypad_calc_top.sv
dv/keypad_calc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP_TB    ?= keypad_calc_tb
TOP_RTL   ?= keypad_calc_top
FILELIST  ?= keypad_calc_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= logic/calc_pkg.sv logic/entry_if.sv logic/key_encoder.sv \
             logic/entry_decoder.sv logic/calc_alu.sv logic/result_unit.sv \
             logic/keypad_calc_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP_TB) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP_TB)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP_RTL) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
